// ==== mera400_params.svh ====
`ifndef MERA400_PARAMS_SVH
`define MERA400_PARAMS_SVH

// --------------------
// clocking
// board clock in Hz
`define CLK_EXT_HZ 50_000_000

// --------------------
// power supply timing, in clock cycles
// off held after reset
`define PON_DLY_TICKS 16
// clo and clm pulse width
`define CLR_TICKS 4

// --------------------
// system bus timing, in clock cycles
`define OK_DLY_TICKS 2
`define BUS_TIMEOUT_TICKS 15

// --------------------
// memory layout
// 4k-word frames fitted
`define MEM_FRAMES 4
// module number answered by this memory
`define MEM_MODULE 1

`endif

// ==== mera400_pkg.sv ====
`default_nettype none

package mera400_pkg;

	// command put on the system bus by the host
	typedef enum logic [1:0] {
		CMD_NONE,
		CMD_READ,
		CMD_WRITE,
		CMD_CONFIG
	} bus_cmd_t;

	// one bus data word, two views
	typedef union packed {
		// plain data for read/write
		logic [15:0] data;
		// configure word for the s strobe
		struct packed {
			// memory module addressed
			logic [3:0] module_nr;
			// physical frame to map
			logic [3:0] frame;
			// unused, kept zero
			logic [7:0] rsvd;
		} cfg;
	} bus_word_u;

endpackage

`default_nettype wire

// ==== sys_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface sys_bus_if;

	// strobes, only one high at a time
	logic w;
	logic r;
	logic s;
	// segment and address
	logic [3:0] nb;
	logic [15:0] ad;
	// data toward the memory
	logic [15:0] dt_m;
	// answer from the memory
	logic ok;
	logic [15:0] dt_s;

	// cpu side drivers
	modport master (
		output w, r, s, nb, ad, dt_m,
		input ok, dt_s
	);

	// memory side
	modport slave (
		input w, r, s, nb, ad, dt_m,
		output ok, dt_s
	);

endinterface

`default_nettype wire

// ==== puks.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mera400_params.svh"

module puks (
	input logic clk,
	input logic rst_n,
	input logic clear_req,
	output logic off,
	output logic clo,
	output logic clm,
	output logic pon
);

	// power-on sequence steps
	enum logic [1:0] {
		ST_OFF,
		ST_CLEARING,
		ST_ON
	} state;

	// shared tick counter for every timed step
	logic [7:0] cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_OFF;
			cnt <= '0;
			off <= 1'b1;
			clo <= 1'b0;
			clm <= 1'b0;
			pon <= 1'b0;
		end else begin
			case (state)
				// supply still coming up
				ST_OFF: begin
					if (cnt == 8'(`PON_DLY_TICKS - 1)) begin
						state <= ST_CLEARING;
						cnt <= '0;
						off <= 1'b0;
						clo <= 1'b1;
						// clear-all wipes memory mapping too
						clm <= 1'b1;
					end else begin
						cnt <= cnt + 8'd1;
					end
				end
				// clear-all pulse
				ST_CLEARING: begin
					if (cnt == 8'(`CLR_TICKS - 1)) begin
						state <= ST_ON;
						cnt <= '0;
						clo <= 1'b0;
						clm <= 1'b0;
					end else begin
						cnt <= cnt + 8'd1;
					end
				end
				// pon one cycle after clo drops, then held
				ST_ON: begin
					pon <= 1'b1;
					if (clm) begin
						// stretch the request into a full clm pulse
						if (cnt == 8'(`CLR_TICKS - 1)) begin
							clm <= 1'b0;
							cnt <= '0;
						end else begin
							cnt <= cnt + 8'd1;
						end
					end else if (clear_req && pon) begin
						clm <= 1'b1;
						cnt <= '0;
					end
				end
				default: state <= ST_OFF;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== mem_elwro.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mera400_params.svh"

module mem_elwro (
	input logic clk,
	input logic rst_n,
	input logic clm,
	sys_bus_if.slave bus
);

	// --------------------
	// storage

	// page table, one entry per segment/page pair
	logic [255:0] pt_valid;
	logic [$clog2(`MEM_FRAMES)-1:0] pt_frame [0:255];
	// physical words
	logic [15:0] words [0:`MEM_FRAMES*4096-1];

	// --------------------
	// decoding

	logic strobe;
	logic [7:0] pg;
	logic [$clog2(`MEM_FRAMES)+11:0] waddr;
	mera400_pkg::bus_word_u cfg_w;
	logic hit_now;
	logic fire;

	// transaction state
	logic seen;
	logic hit;
	logic ok_q;
	logic [3:0] cnt;
	logic [15:0] dt_q;

	assign strobe = bus.w | bus.r | bus.s;
	// segment plus top four address bits
	assign pg = {bus.nb, bus.ad[15:12]};
	// frame from table, offset within the 4k page
	assign waddr = {pt_frame[pg], bus.ad[11:0]};
	assign cfg_w = bus.dt_m;

	// configure: only our module number answers
	// read/write: only mapped pages answer
	assign hit_now = bus.s ? (cfg_w.cfg.module_nr == 4'(`MEM_MODULE)) : pt_valid[pg];

	// the cycle in which the command takes effect and ok rises
	assign fire = strobe && seen && hit && !ok_q && (cnt == 4'(`OK_DLY_TICKS));

	assign bus.ok = ok_q;
	assign bus.dt_s = dt_q;

	// --------------------
	// bus handshake
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			seen <= 1'b0;
			hit <= 1'b0;
			ok_q <= 1'b0;
			cnt <= '0;
		end else if (!strobe) begin
			// strobe gone, ready for next one
			seen <= 1'b0;
			ok_q <= 1'b0;
		end else if (!seen) begin
			// first look, decide once whether to answer
			seen <= 1'b1;
			hit <= hit_now;
			cnt <= 4'd1;
		end else if (fire) begin
			ok_q <= 1'b1;
		end else if (hit && !ok_q) begin
			cnt <= cnt + 4'd1;
		end
	end

	// valid bits, wiped by reset and by clm
	always_ff @(posedge clk) begin
		if (!rst_n || clm) begin
			pt_valid <= '0;
		end else if (fire && bus.s) begin
			// frames past the end stay unmapped
			pt_valid[pg] <= (5'(cfg_w.cfg.frame) < 5'(`MEM_FRAMES));
		end
	end

	// frame numbers, words and read data
	always_ff @(posedge clk) begin
		if (fire && bus.s) begin
			pt_frame[pg] <= cfg_w.cfg.frame[$clog2(`MEM_FRAMES)-1:0];
		end
		if (fire && bus.w) begin
			words[waddr] <= bus.dt_m;
		end
		// held on dt_s while ok is up
		if (fire && bus.r) begin
			dt_q <= words[waddr];
		end
	end

endmodule

`default_nettype wire

// ==== bus_host.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mera400_params.svh"

module bus_host (
	input logic clk,
	input logic rst_n,
	input logic clm,
	input logic pon,
	input logic start,
	input mera400_pkg::bus_cmd_t cmd,
	input logic [3:0] nb,
	input logic [15:0] addr,
	input logic [15:0] wdata,
	output logic [15:0] rdata,
	output logic busy,
	output logic done,
	output logic nomem,
	sys_bus_if.master bus
);

	logic accept;
	// strobe drivers
	logic w_q;
	logic r_q;
	logic s_q;
	// latched command payload
	logic [3:0] nb_q;
	logic [15:0] ad_q;
	mera400_pkg::bus_word_u dt_q;
	// cycles spent waiting for ok
	logic [7:0] tcnt;

	assign accept = start && pon && !busy && (cmd != mera400_pkg::CMD_NONE);

	assign bus.w = w_q;
	assign bus.r = r_q;
	assign bus.s = s_q;
	assign bus.nb = nb_q;
	assign bus.ad = ad_q;
	assign bus.dt_m = dt_q.data;

	// --------------------
	// command sequencing, clm drops everything without done
	always_ff @(posedge clk) begin
		if (!rst_n || clm) begin
			busy <= 1'b0;
			done <= 1'b0;
			nomem <= 1'b0;
			w_q <= 1'b0;
			r_q <= 1'b0;
			s_q <= 1'b0;
			tcnt <= '0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				if (accept) begin
					busy <= 1'b1;
					nomem <= 1'b0;
					tcnt <= '0;
					w_q <= (cmd == mera400_pkg::CMD_WRITE);
					r_q <= (cmd == mera400_pkg::CMD_READ);
					s_q <= (cmd == mera400_pkg::CMD_CONFIG);
				end
			end else if (bus.ok) begin
				// answered, release the bus
				{w_q, r_q, s_q} <= 3'b000;
				busy <= 1'b0;
				done <= 1'b1;
			end else if (tcnt == 8'(`BUS_TIMEOUT_TICKS - 1)) begin
				// nobody home
				{w_q, r_q, s_q} <= 3'b000;
				busy <= 1'b0;
				done <= 1'b1;
				nomem <= 1'b1;
			end else begin
				tcnt <= tcnt + 8'd1;
			end
		end
	end

	// payload, held steady while the strobe is up
	always_ff @(posedge clk) begin
		if (accept) begin
			nb_q <= nb;
			ad_q <= addr;
			dt_q.data <= wdata;
			// reserved field of a configure word goes out as zero
			if (cmd == mera400_pkg::CMD_CONFIG) begin
				dt_q.cfg.rsvd <= '0;
			end
		end
		if (busy && bus.ok && r_q) begin
			rdata <= bus.dt_s;
		end
	end

endmodule

`default_nettype wire

// ==== mera400_sys.sv ====
`timescale 1ns/1ps
`default_nettype none

module mera400_sys (
	input logic clk_ext,
	input logic rst_n,
	// memory clear button
	input logic clear_req,
	// one command toward the bus
	input logic start,
	input mera400_pkg::bus_cmd_t cmd,
	input logic [3:0] nb,
	input logic [15:0] addr,
	input logic [15:0] wdata,
	output logic [15:0] rdata,
	output logic busy,
	output logic done,
	output logic nomem,
	// supply state
	output logic off,
	output logic pon
);

	logic clm;

	// --------------------
	// system bus
	sys_bus_if u_bus ();

	// --------------------
	// power supply
	// clo would reset the cpu, which is not fitted
	puks u_puks (
		.clk(clk_ext),
		.rst_n(rst_n),
		.clear_req(clear_req),
		.off(off),
		.clo(),
		.clm(clm),
		.pon(pon)
	);

	// --------------------
	// cpu bus drivers
	bus_host u_bus_host (
		.clk(clk_ext),
		.rst_n(rst_n),
		.clm(clm),
		.pon(pon),
		.start(start),
		.cmd(cmd),
		.nb(nb),
		.addr(addr),
		.wdata(wdata),
		.rdata(rdata),
		.busy(busy),
		.done(done),
		.nomem(nomem),
		.bus(u_bus.master)
	);

	// --------------------
	// memory
	mem_elwro u_mem (
		.clk(clk_ext),
		.rst_n(rst_n),
		.clm(clm),
		.bus(u_bus.slave)
	);

endmodule

`default_nettype wire

// ==== mera400_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mera400_params.svh"

module mera400_assert (
	input logic clk,
	input logic rst_n,
	input logic w,
	input logic r,
	input logic s,
	input logic ok,
	input logic clm,
	input logic done,
	input logic off,
	input logic pon
);

	logic strobe;
	// cycles the current strobe has been up
	logic [7:0] held;

	assign strobe = w | r | s;

	always_ff @(posedge clk) begin
		if (!rst_n || !strobe) begin
			held <= '0;
		end else begin
			held <= held + 8'd1;
		end
	end

	// --------------------
	// bus side
	// never two strobes at once
	a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({w, r, s})) else $error("more than one bus strobe high");

	// strobe only drops after ok or once the timeout is used up
	a_strobe_held: assert property (@(posedge clk) disable iff (!rst_n)
		strobe && !ok && !clm && held < 8'(`BUS_TIMEOUT_TICKS - 1) |=> strobe)
		else $error("strobe dropped before ok or timeout");

	// single-cycle done
	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done) else $error("done held longer than one cycle");

	// --------------------
	// power side
	a_off_pon: assert property (@(posedge clk) disable iff (!rst_n)
		!(off && pon)) else $error("off and pon high together");

endmodule

// host carries the bus rules, off not visible there
bind bus_host mera400_assert u_host_chk (
	.clk(clk),
	.rst_n(rst_n),
	.w(w_q),
	.r(r_q),
	.s(s_q),
	.ok(bus.ok),
	.clm(clm),
	.done(done),
	.off(1'b0),
	.pon(pon)
);

// supply sequencer, no bus here
bind puks mera400_assert u_puks_chk (
	.clk(clk),
	.rst_n(rst_n),
	.w(1'b0),
	.r(1'b0),
	.s(1'b0),
	.ok(1'b0),
	.clm(clm),
	.done(1'b0),
	.off(off),
	.pon(pon)
);

`default_nettype wire

// ==== mera400_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mera400_params.svh"

module mera400_tb;

	logic clk;
	logic rst_n;
	logic clear_req;
	logic start;
	mera400_pkg::bus_cmd_t cmd;
	logic [3:0] nb;
	logic [15:0] addr;
	logic [15:0] wdata;
	logic [15:0] rdata;
	logic busy;
	logic done;
	logic nomem;
	logic off;
	logic pon;

	int errors;
	int checks;
	int tests;

	// reference model, page table plus every word written so far
	logic map_valid [0:255];
	int map_frame [0:255];
	logic [15:0] ref_mem [int];

	mera400_sys u_dut (
		.clk_ext(clk),
		.rst_n(rst_n),
		.clear_req(clear_req),
		.start(start),
		.cmd(cmd),
		.nb(nb),
		.addr(addr),
		.wdata(wdata),
		.rdata(rdata),
		.busy(busy),
		.done(done),
		.nomem(nomem),
		.off(off),
		.pon(pon)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	// --------------------
	// helpers

	task automatic compare(input string what, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got %h, expected %h", what, got, exp);
		end
	endtask

	// nomem as expected, done inside the window for that outcome
	task automatic check_finish(input logic nm, input int lat, input logic exp_nm);
		int limit;
		limit = exp_nm ? `BUS_TIMEOUT_TICKS + 3 : `OK_DLY_TICKS + 3;
		compare("nomem", 16'(nm), 16'(exp_nm));
		checks++;
		if (lat > limit) begin
			errors++;
			$display("done came %0d cycles after start, limit is %0d", lat, limit);
		end
	endtask

	// word index in memory, -1 for an unmapped page
	function automatic int phys_addr(input logic [3:0] seg, input logic [15:0] a);
		int pg;
		pg = int'({seg, a[15:12]});
		if (!map_valid[pg]) begin
			return -1;
		end
		return map_frame[pg] * 4096 + int'(a[11:0]);
	endfunction

	// one start pulse, then wait for done with a cycle cap
	task automatic bus_op(input mera400_pkg::bus_cmd_t c, input logic [3:0] seg,
			input logic [15:0] a, input logic [15:0] d,
			output logic [15:0] rd, output logic nm, output int lat);
		int n;
		logic busy_seen_low;
		@(posedge clk);
		#1;
		start = 1'b1;
		cmd = c;
		nb = seg;
		addr = a;
		wdata = d;
		@(posedge clk);
		#1;
		start = 1'b0;
		cmd = mera400_pkg::CMD_NONE;
		// edges counted from the one that took start
		n = 0;
		busy_seen_low = 1'b0;
		while (!done && n < `BUS_TIMEOUT_TICKS + 10) begin
			// busy covers the whole command
			if (!busy) begin
				busy_seen_low = 1'b1;
			end
			@(posedge clk);
			#1;
			n++;
		end
		checks++;
		if (busy_seen_low) begin
			errors++;
			$display("busy low while a command was in flight");
		end
		if (!done) begin
			errors++;
			$display("no done within %0d cycles of a start", n);
		end else begin
			compare("busy", 16'(busy), 16'h0000);
		end
		rd = rdata;
		nm = nomem;
		lat = n;
	endtask

	task automatic configure(input logic [3:0] seg, input logic [3:0] page,
			input logic [3:0] module_nr, input logic [3:0] frame);
		mera400_pkg::bus_word_u w;
		logic [15:0] rd;
		logic nm;
		int lat;
		int pg;
		w.cfg.module_nr = module_nr;
		w.cfg.frame = frame;
		w.cfg.rsvd = 8'h00;
		pg = int'({seg, page});
		bus_op(mera400_pkg::CMD_CONFIG, seg, {page, 12'h000}, w.data, rd, nm, lat);
		if (module_nr == 4'(`MEM_MODULE)) begin
			// frames past the end leave the page unmapped
			map_valid[pg] = (int'(frame) < `MEM_FRAMES);
			map_frame[pg] = int'(frame);
			check_finish(nm, lat, 1'b0);
		end else begin
			check_finish(nm, lat, 1'b1);
		end
	endtask

	task automatic write_word(input logic [3:0] seg, input logic [15:0] a,
			input logic [15:0] d);
		logic [15:0] rd;
		logic nm;
		int lat;
		int pa;
		pa = phys_addr(seg, a);
		bus_op(mera400_pkg::CMD_WRITE, seg, a, d, rd, nm, lat);
		if (pa >= 0) begin
			ref_mem[pa] = d;
		end
		check_finish(nm, lat, pa < 0);
	endtask

	task automatic read_check(input logic [3:0] seg, input logic [15:0] a);
		logic [15:0] rd;
		logic nm;
		int lat;
		int pa;
		pa = phys_addr(seg, a);
		bus_op(mera400_pkg::CMD_READ, seg, a, 16'h0000, rd, nm, lat);
		check_finish(nm, lat, pa < 0);
		if (pa >= 0 && ref_mem.exists(pa)) begin
			compare("rdata", rd, ref_mem[pa]);
		end
	endtask

	task automatic report(input string name, input int e0);
		tests++;
		$display("%s: %0d error(s)", name, errors - e0);
	endtask

	// --------------------
	// tests

	task automatic power_on_seq();
		int e0;
		int n;
		e0 = errors;
		#1;
		rst_n = 1'b1;
		compare("off", 16'(off), 16'h0001);
		compare("pon", 16'(pon), 16'h0000);
		n = 0;
		while (!pon && n < 100) begin
			@(posedge clk);
			#1;
			n++;
		end
		checks++;
		if (n != `PON_DLY_TICKS + `CLR_TICKS + 1) begin
			errors++;
			$display("pon rose %0d cycles after reset, expected %0d", n,
				`PON_DLY_TICKS + `CLR_TICKS + 1);
		end
		compare("off", 16'(off), 16'h0000);
		report("power-on", e0);
	endtask

	task automatic unmapped_read();
		int e0;
		e0 = errors;
		read_check(4'h0, 16'h1234);
		report("unmapped read", e0);
	endtask

	task automatic config_write_read();
		int e0;
		int i;
		logic [3:0] segs [0:19];
		logic [15:0] addrs [0:19];
		e0 = errors;
		configure(4'h0, 4'h1, 4'(`MEM_MODULE), 4'h0);
		configure(4'h2, 4'h3, 4'(`MEM_MODULE), 4'h1);
		for (i = 0; i < 20; i++) begin
			// pick one of the two mapped pages
			if ($urandom % 2 == 0) begin
				segs[i] = 4'h0;
				addrs[i] = {4'h1, 12'($urandom)};
			end else begin
				segs[i] = 4'h2;
				addrs[i] = {4'h3, 12'($urandom)};
			end
			write_word(segs[i], addrs[i], 16'($urandom));
		end
		for (i = 0; i < 20; i++) begin
			read_check(segs[i], addrs[i]);
		end
		report("configure/write/read", e0);
	endtask

	task automatic alias_and_reject();
		int e0;
		e0 = errors;
		// two pages on frame 2
		configure(4'h1, 4'h2, 4'(`MEM_MODULE), 4'h2);
		configure(4'h3, 4'h5, 4'(`MEM_MODULE), 4'h2);
		write_word(4'h1, 16'h2abc, 16'h5a5a);
		read_check(4'h3, 16'h5abc);
		write_word(4'h3, 16'h5010, 16'hc3c3);
		read_check(4'h1, 16'h2010);
		// other module number, no answer
		configure(4'h4, 4'h0, 4'(`MEM_MODULE + 1), 4'h3);
		read_check(4'h4, 16'h0010);
		// frame out of range
		configure(4'h5, 4'h7, 4'(`MEM_MODULE), 4'(`MEM_FRAMES));
		read_check(4'h5, 16'h7000);
		report("aliasing and rejects", e0);
	endtask

	task automatic memory_clear();
		int e0;
		int i;
		e0 = errors;
		@(posedge clk);
		#1;
		clear_req = 1'b1;
		@(posedge clk);
		#1;
		clear_req = 1'b0;
		for (i = 0; i < 256; i++) begin
			map_valid[i] = 1'b0;
		end
		// clm pulse, pon must hold
		repeat (`CLR_TICKS + 2) begin
			@(posedge clk);
			#1;
			compare("pon", 16'(pon), 16'h0001);
		end
		read_check(4'h0, 16'h1000);
		read_check(4'h2, 16'h3000);
		read_check(4'h1, 16'h2abc);
		compare("pon", 16'(pon), 16'h0001);
		report("memory clear", e0);
	endtask

	task automatic back_pressure();
		int e0;
		int nd;
		e0 = errors;
		configure(4'h6, 4'h1, 4'(`MEM_MODULE), 4'h3);
		write_word(4'h6, 16'h1100, 16'h1111);
		@(posedge clk);
		#1;
		start = 1'b1;
		cmd = mera400_pkg::CMD_WRITE;
		nb = 4'h6;
		addr = 16'h1000;
		wdata = 16'hbeef;
		@(posedge clk);
		#1;
		// second start lands while busy
		addr = 16'h1100;
		wdata = 16'hdead;
		@(posedge clk);
		#1;
		start = 1'b0;
		cmd = mera400_pkg::CMD_NONE;
		nd = 0;
		repeat (20) begin
			@(posedge clk);
			#1;
			if (done) begin
				nd++;
			end
		end
		checks++;
		if (nd != 1) begin
			errors++;
			$display("%0d done pulses after two starts, expected 1", nd);
		end
		ref_mem[phys_addr(4'h6, 16'h1000)] = 16'hbeef;
		read_check(4'h6, 16'h1100);
		read_check(4'h6, 16'h1000);
		report("back-pressure", e0);
	endtask

	// --------------------
	// main sequence
	initial begin
		int i;
		clk = 1'b0;
		rst_n = 1'b0;
		clear_req = 1'b0;
		start = 1'b0;
		cmd = mera400_pkg::CMD_NONE;
		nb = 4'h0;
		addr = 16'h0000;
		wdata = 16'h0000;
		errors = 0;
		checks = 0;
		tests = 0;
		void'($urandom(32'hcc42));
		for (i = 0; i < 256; i++) begin
			map_valid[i] = 1'b0;
			map_frame[i] = 0;
		end
		repeat (8) @(posedge clk);
		power_on_seq();
		unmapped_read();
		config_write_read();
		alias_and_reject();
		memory_clear();
		back_pressure();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// watchdog, worst case commands plus power-on
	initial begin
		int limit;
		limit = 5 * 40 * (`BUS_TIMEOUT_TICKS + 10) + 8 + `PON_DLY_TICKS + `CLR_TICKS + 1;
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles, run stopped", limit);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
mera400_pkg.sv
sys_bus_if.sv
puks.sv
mem_elwro.sv
bus_host.sv
mera400_sys.sv
mera400_assert.sv
mera400_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with verilator, run, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module mera400_tb \
	-o mera400_sim > build.log 2>&1 \
	&& ./obj_dir/mera400_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "FAIL: build or run stopped"; exit 1; }

cat sim.log
grep -q "^Done: no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
